/* Makefile */
TOP = calc_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing -f flist.f --top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* flist.f */
verilog/calc_pkg.sv
verilog/keypad_scanner.sv
verilog/calc_controller.sv
verilog/calc_alu.sv
verilog/calc_top.sv
sim/tb_clock.sv
sim/calc_tb.sv

/* sim/calc_tb.sv */
module calc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import calc_pkg::*;

    localparam int SCAN_CYCLES     = 8;
    localparam int DEBOUNCE_CYCLES = 20;
    localparam int PRESS_LIMIT     = 300;    // cycles to wait for a click
    localparam int SETTLE_CYCLES   = 20;     // after release, before checking
    localparam int PRESS_COUNT     = 210;    // rough upper bound of presses over all tests
    localparam int WATCHDOG_CYCLES = PRESS_COUNT * 400 + 2000;
    localparam int VAL_MAX         = 32767;
    localparam int VAL_MIN         = -32768;

    // model states
    localparam int M_ENTRY_A = 0;
    localparam int M_ENTRY_B = 1;
    localparam int M_RESULT  = 2;

    logic               clk;
    logic               nRST;
    logic [3:0]         row_in = 4'b1111;   // nothing pressed
    logic [3:0]         col_out;
    logic signed [15:0] display_value;
    logic               overflow;
    logic               key_click;

    logic     key_down;           // keypad model, a key is held
    key_pos_t held_pos;
    int       click_count = 0;
    int       errors;
    int       tests_run;
    int       tests_failed;

    // controller model
    int   m_a;
    int   m_b;
    int   m_cnt;                  // digits in the operand being entered
    int   m_state;
    op_t  m_op;
    logic m_neg;
    logic m_ovf;

    tb_clock i_clock (.clk(clk));

    calc_top #(
        .OPERAND_W       (OPERAND_W_DEFAULT),
        .SCAN_CYCLES     (SCAN_CYCLES),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) i_dut (
        .clk           (clk),
        .nRST          (nRST),
        .row_in        (row_in),
        .col_out       (col_out),
        .display_value (display_value),
        .overflow      (overflow),
        .key_click     (key_click)
    );

    // row of the held key goes low only while its column is driven low
    always @(negedge clk) begin
        if (key_down && !col_out[held_pos[1:0]]) begin
            row_in <= ~(4'b0001 << held_pos[3:2]);
        end else begin
            row_in <= 4'b1111;
        end
    end

    always @(posedge clk) begin
        if (key_click) begin
            click_count <= click_count + 1;   // one per applied key
        end
    end

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
        errors++;
    endtask

    // digits 1-9 fill a 3x3 block from position 0, zero sits below
    function automatic key_pos_t digit_to_pos(input int d);
        if (d == 0) begin
            return POS_ZERO;
        end
        return key_pos_t'(((d - 1) / 3) * 4 + (d - 1) % 3);
    endfunction

    function automatic int rand_operand();
        int v;
        v = int'($urandom_range(999));
        if ($urandom_range(1) == 1) begin
            v = -v;
        end
        return v;
    endfunction

    task automatic clear_model();
        m_a     = 0;
        m_b     = 0;
        m_cnt   = 0;
        m_neg   = 1'b0;
        m_op    = OP_NONE;
        m_ovf   = 1'b0;
        m_state = M_ENTRY_A;
    endtask

    // A op B into A, clamped to 16 bits
    task automatic compute_into_a();
        longint full;
        case (m_op)
            OP_ADD:  full = longint'(m_a) + longint'(m_b);
            OP_SUB:  full = longint'(m_a) - longint'(m_b);
            OP_MUL:  full = longint'(m_a) * longint'(m_b);
            default: full = longint'(m_a);
        endcase
        if (full > longint'(VAL_MAX)) begin
            m_a   = VAL_MAX;
            m_ovf = 1'b1;
        end else if (full < longint'(VAL_MIN)) begin
            m_a   = VAL_MIN;
            m_ovf = 1'b1;
        end else begin
            m_a = int'(full);
        end
    endtask

    task automatic model_key(input key_pos_t pos);
        int d;
        d = 0;
        for (int k = 1; k < 10; k++) begin
            if (digit_to_pos(k) == pos) begin
                d = k;   // digit whose key sits here
            end
        end
        case (pos)
            POS_CLEAR: clear_model();
            POS_MINUS: begin
                if (m_state == M_RESULT) begin
                    m_a     = 0;              // fresh negative A
                    m_cnt   = 0;
                    m_neg   = 1'b1;
                    m_state = M_ENTRY_A;
                end else if (m_cnt == 0) begin
                    m_neg = 1'b1;
                end
            end
            POS_ADD, POS_SUB, POS_MUL: begin
                if (m_state == M_ENTRY_B && m_cnt != 0) begin
                    compute_into_a();         // chained operation
                end
                if (pos == POS_ADD) begin
                    m_op = OP_ADD;
                end else if (pos == POS_SUB) begin
                    m_op = OP_SUB;
                end else begin
                    m_op = OP_MUL;
                end
                m_b     = 0;
                m_cnt   = 0;
                m_neg   = 1'b0;
                m_state = M_ENTRY_B;
            end
            POS_EQUALS: begin
                if (m_state == M_ENTRY_B && m_cnt != 0) begin
                    compute_into_a();
                    m_op    = OP_NONE;
                    m_b     = 0;
                    m_cnt   = 0;
                    m_neg   = 1'b0;
                    m_state = M_RESULT;
                end
            end
            default: begin
                if (m_state == M_RESULT) begin
                    m_a     = d;
                    m_cnt   = 1;
                    m_neg   = 1'b0;
                    m_state = M_ENTRY_A;
                end else if (m_cnt < MAX_DIGITS) begin
                    if (m_state == M_ENTRY_A) begin
                        m_a = m_neg ? m_a * 10 - d : m_a * 10 + d;
                    end else begin
                        m_b = m_neg ? m_b * 10 - d : m_b * 10 + d;
                    end
                    m_cnt++;
                end
            end
        endcase
    endtask

    task automatic check_outputs();
        int exp_disp;
        exp_disp = (m_state == M_ENTRY_B && m_cnt != 0) ? m_b : m_a;   // empty B shows A
        if (int'(display_value) != exp_disp) begin
            report_mismatch("display_value", exp_disp, int'(display_value));
        end
        if (overflow != m_ovf) begin
            report_mismatch("overflow", int'(m_ovf), int'(overflow));
        end
    endtask

    // hold until the click, release, let things settle, compare with the model
    task automatic press_key(input key_pos_t pos);
        int waited;
        waited = 0;
        @(negedge clk);
        held_pos <= pos;
        key_down <= 1'b1;
        @(negedge clk);
        while (!key_click && waited < PRESS_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        key_down <= 1'b0;
        if (!key_click) begin
            $display("Key at position %0d was not acknowledged within %0d cycles",
                     pos, PRESS_LIMIT);
            errors++;
        end else begin
            model_key(pos);
        end
        repeat (SETTLE_CYCLES) @(negedge clk);
        check_outputs();
    endtask

    task automatic hold_key(input key_pos_t pos, input int cycles);
        @(negedge clk);
        held_pos <= pos;
        key_down <= 1'b1;
        repeat (cycles) @(negedge clk);
        key_down <= 1'b0;
        repeat (SETTLE_CYCLES) @(negedge clk);
    endtask

    task automatic enter_number(input int value);
        int mag;
        int digs[$];
        mag = (value < 0) ? -value : value;
        if (value < 0) begin
            press_key(POS_MINUS);
        end
        do begin
            digs.push_front(mag % 10);
            mag = mag / 10;
        end while (mag > 0);
        foreach (digs[i]) begin
            press_key(digit_to_pos(digs[i]));
        end
    endtask

    task automatic scan_and_key_map();
        bit [3:0] seen;
        seen = '0;
        repeat ((SCAN_CYCLES + 1) * 4 + 4) begin   // a full column cycle and a bit
            @(negedge clk);
            if ($countones(~col_out) != 1) begin
                report_mismatch("low bits of col_out", 1, $countones(~col_out));
            end
            for (int c = 0; c < 4; c++) begin
                if (!col_out[c]) begin
                    seen[c] = 1'b1;
                end
            end
        end
        if (seen != 4'b1111) begin
            $display("Scanner drove only columns %b low, not all four", seen);
            errors++;
        end
        for (int d = 0; d < 10; d++) begin
            press_key(POS_CLEAR);
            press_key(digit_to_pos(d));
            if (int'(display_value) != d) begin
                report_mismatch("display_value", d, int'(display_value));
            end
        end
    endtask

    task automatic operand_entry();
        press_key(POS_CLEAR);
        enter_number(-1234);
        press_key(digit_to_pos(5));   // fifth digit, dropped
        press_key(POS_MINUS);         // too late for a sign
        if (int'(display_value) != -1234) begin
            report_mismatch("display_value", -1234, int'(display_value));
        end
        press_key(POS_CLEAR);
        press_key(digit_to_pos(7));
        press_key(POS_MINUS);
        press_key(digit_to_pos(8));
        if (int'(display_value) != 78) begin
            report_mismatch("display_value", 78, int'(display_value));
        end
    endtask

    task automatic random_arithmetic();
        key_pos_t op_keys[3] = '{POS_ADD, POS_SUB, POS_MUL};
        for (int i = 0; i < 3; i++) begin
            repeat (4) begin
                press_key(POS_CLEAR);
                enter_number(rand_operand());
                press_key(op_keys[i]);
                enter_number(rand_operand());
                press_key(POS_EQUALS);
            end
        end
    endtask

    task automatic chained_ops();
        press_key(POS_CLEAR);
        enter_number(12);
        press_key(POS_ADD);
        enter_number(34);
        press_key(POS_MUL);           // 46 shows here
        enter_number(5);
        press_key(POS_EQUALS);
        if (int'(display_value) != 230) begin
            report_mismatch("display_value", 230, int'(display_value));
        end
        press_key(digit_to_pos(7));   // new A after a result
        press_key(POS_SUB);
        enter_number(3);
        press_key(POS_EQUALS);
        if (int'(display_value) != 4) begin
            report_mismatch("display_value", 4, int'(display_value));
        end
    endtask

    task automatic overflow_and_clear();
        press_key(POS_CLEAR);
        enter_number(999);
        press_key(POS_MUL);
        enter_number(999);
        press_key(POS_EQUALS);
        if (int'(display_value) != VAL_MAX) begin
            report_mismatch("display_value", VAL_MAX, int'(display_value));
        end
        if (overflow != 1'b1) begin
            report_mismatch("overflow", 1, int'(overflow));
        end
        press_key(POS_MUL);
        enter_number(2);
        press_key(POS_EQUALS);        // clamped again, flag stays
        press_key(POS_CLEAR);
        if (int'(display_value) != 0) begin
            report_mismatch("display_value", 0, int'(display_value));
        end
        if (overflow != 1'b0) begin
            report_mismatch("overflow", 0, int'(overflow));
        end
        enter_number(-999);
        press_key(POS_MUL);
        enter_number(999);
        press_key(POS_EQUALS);        // lower limit
        press_key(POS_CLEAR);
    endtask

    task automatic bounce_and_hold();
        int clicks_before;
        int disp_before;
        press_key(POS_CLEAR);
        press_key(digit_to_pos(3));
        clicks_before = click_count;
        disp_before   = int'(display_value);
        repeat (6) begin
            @(negedge clk);
            held_pos <= digit_to_pos(5);
            key_down <= 1'b1;
            repeat ($urandom_range(DEBOUNCE_CYCLES - 6, 3)) @(negedge clk);
            key_down <= 1'b0;         // contact opens
            repeat ($urandom_range(3, 1)) @(negedge clk);
        end
        repeat (40) @(negedge clk);
        if (click_count != clicks_before) begin
            report_mismatch("key_click count", clicks_before, click_count);
        end
        if (int'(display_value) != disp_before) begin
            report_mismatch("display_value", disp_before, int'(display_value));
        end
        clicks_before = click_count;
        hold_key(digit_to_pos(5), 200);   // long hold, no repeat
        if (click_count != clicks_before + 1) begin
            report_mismatch("key_click count", clicks_before + 1, click_count);
        end
        model_key(digit_to_pos(5));
        check_outputs();
    endtask

    task automatic record_result(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int e;
        void'($urandom(97));
        nRST         = 1'b0;
        key_down     = 1'b0;
        held_pos     = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        clear_model();
        repeat (8) @(posedge clk);
        @(negedge clk);
        nRST <= 1'b1;

        e = errors;
        scan_and_key_map();
        record_result("scan and key map", e);
        e = errors;
        operand_entry();
        record_result("operand entry", e);
        e = errors;
        random_arithmetic();
        record_result("arithmetic", e);
        e = errors;
        chained_ops();
        record_result("chaining and restart", e);
        e = errors;
        overflow_and_clear();
        record_result("overflow and clear", e);
        e = errors;
        bounce_and_hold();
        record_result("debounce", e);

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // ends a hung run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* sim/tb_clock.sv */
module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;   // 4 ns period
        end
    end

endmodule

/* verilog/calc_alu.sv */
module calc_alu #(
    parameter int OPERAND_W = calc_pkg::OPERAND_W_DEFAULT
) (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic                        alu_start,
    input  calc_pkg::op_t               alu_op,
    input  logic signed [OPERAND_W-1:0] alu_a,
    input  logic signed [OPERAND_W-1:0] alu_b,
    output logic                        alu_done,      // one cycle after alu_start
    output logic signed [OPERAND_W-1:0] alu_result,    // clamped on overflow
    output logic                        alu_overflow
);
    import calc_pkg::*;

    localparam int WIDE_W = 2 * OPERAND_W;   // room for a full product

    typedef logic signed [OPERAND_W-1:0] operand_t;
    typedef logic signed [WIDE_W-1:0]    wide_t;

    // signed operand range, carried at full width
    localparam wide_t RES_MAX = {{(OPERAND_W + 1){1'b0}}, {(OPERAND_W - 1){1'b1}}};
    localparam wide_t RES_MIN = {{(OPERAND_W + 1){1'b1}}, {(OPERAND_W - 1){1'b0}}};

    wide_t    a_w;
    wide_t    b_w;
    wide_t    full;       // exact result
    logic     too_big;
    logic     too_small;
    operand_t clamped;

    assign a_w = wide_t'(alu_a);   // sign extended
    assign b_w = wide_t'(alu_b);

    always_comb begin
        case (alu_op)
            OP_ADD:  full = a_w + b_w;
            OP_SUB:  full = a_w - b_w;
            OP_MUL:  full = a_w * b_w;
            default: full = a_w;     // no operator passes A
        endcase
    end

    assign too_big   = (full > RES_MAX);
    assign too_small = (full < RES_MIN);

    always_comb begin
        if (too_big) begin
            clamped = RES_MAX[OPERAND_W-1:0];
        end else if (too_small) begin
            clamped = RES_MIN[OPERAND_W-1:0];
        end else begin
            clamped = full[OPERAND_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            alu_done <= 1'b0;
        end else begin
            alu_done <= alu_start;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_start) begin
            alu_result   <= clamped;
            alu_overflow <= too_big | too_small;
        end
    end

endmodule

/* verilog/calc_controller.sv */
module calc_controller #(
    parameter int OPERAND_W = calc_pkg::OPERAND_W_DEFAULT
) (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic                        key_ready,
    input  calc_pkg::key_class_t        key_class,
    input  calc_pkg::digit_t            key_digit,
    input  calc_pkg::op_t               key_op,
    output logic                        key_ack,       // one cycle per applied key
    output logic                        alu_start,
    output calc_pkg::op_t               alu_op,
    output logic signed [OPERAND_W-1:0] alu_a,
    output logic signed [OPERAND_W-1:0] alu_b,
    input  logic                        alu_done,
    input  logic signed [OPERAND_W-1:0] alu_result,
    input  logic                        alu_overflow,
    output logic signed [OPERAND_W-1:0] display_value,
    output logic                        overflow       // sticky until clear
);
    import calc_pkg::*;

    localparam int CNT_W = $clog2(MAX_DIGITS + 1);

    typedef logic signed [OPERAND_W-1:0] operand_t;
    typedef logic [CNT_W-1:0]            digit_cnt_t;

    typedef enum logic [1:0] {
        ST_ENTRY_A,   // building the first operand
        ST_ENTRY_B,   // operator latched, building the second
        ST_WAIT_ALU,  // keys held off until alu_done
        ST_RESULT     // A holds a finished result
    } state_t;

    localparam operand_t TEN = operand_t'(10);

    state_t     state;
    operand_t   opd_a;
    operand_t   opd_b;
    digit_cnt_t digit_cnt;    // digits in the operand being entered
    logic       neg;          // minus pressed before the first digit
    op_t        op_reg;       // operator between A and B
    op_t        pending_op;   // operator to latch once the ALU answers
    logic       take_key;
    logic       room;

    // shift in one decimal digit, sign already applied to the running value
    function automatic operand_t append_digit(input operand_t value, input logic negative,
                                              input digit_t d);
        operand_t dv;
        dv = operand_t'(d);
        return negative ? (value * TEN) - dv : (value * TEN) + dv;
    endfunction

    assign take_key = key_ready && !key_ack && (state != ST_WAIT_ALU);
    assign room     = (digit_cnt < digit_cnt_t'(MAX_DIGITS));

    assign alu_a  = opd_a;
    assign alu_b  = opd_b;
    assign alu_op = op_reg;

    always_comb begin
        case (state)
            ST_ENTRY_B, ST_WAIT_ALU: display_value = (digit_cnt == '0) ? opd_a : opd_b;
            default:                 display_value = opd_a;  // entry A or result
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state      <= ST_ENTRY_A;
            opd_a      <= '0;
            opd_b      <= '0;
            digit_cnt  <= '0;
            neg        <= 1'b0;
            op_reg     <= OP_NONE;
            pending_op <= OP_NONE;
            overflow   <= 1'b0;
            key_ack    <= 1'b0;
            alu_start  <= 1'b0;
        end else begin
            key_ack   <= take_key;
            alu_start <= 1'b0;
            if (state == ST_WAIT_ALU) begin
                if (alu_done) begin
                    opd_a     <= alu_result;            // result becomes the new A
                    overflow  <= overflow | alu_overflow;
                    op_reg    <= pending_op;
                    opd_b     <= '0;
                    digit_cnt <= '0;
                    neg       <= 1'b0;
                    state     <= (pending_op == OP_NONE) ? ST_RESULT : ST_ENTRY_B;
                end
            end else if (take_key) begin
                case (key_class)
                    KEY_CLEAR: begin
                        opd_a     <= '0;
                        opd_b     <= '0;
                        digit_cnt <= '0;
                        neg       <= 1'b0;
                        op_reg    <= OP_NONE;
                        overflow  <= 1'b0;
                        state     <= ST_ENTRY_A;
                    end
                    KEY_DIGIT: begin
                        if (state == ST_RESULT) begin
                            opd_a     <= append_digit('0, 1'b0, key_digit);  // fresh A
                            digit_cnt <= digit_cnt_t'(1);
                            neg       <= 1'b0;
                            state     <= ST_ENTRY_A;
                        end else if (room) begin
                            if (state == ST_ENTRY_A) begin
                                opd_a <= append_digit(opd_a, neg, key_digit);
                            end else begin
                                opd_b <= append_digit(opd_b, neg, key_digit);
                            end
                            digit_cnt <= digit_cnt + 1'b1;
                        end
                    end
                    KEY_MINUS: begin
                        if (state == ST_RESULT) begin
                            opd_a     <= '0;          // starts a fresh negative A
                            digit_cnt <= '0;
                            neg       <= 1'b1;
                            state     <= ST_ENTRY_A;
                        end else if (digit_cnt == '0) begin
                            neg <= 1'b1;
                        end
                    end
                    KEY_OP: begin
                        if (state == ST_ENTRY_B && digit_cnt != '0) begin
                            alu_start  <= 1'b1;       // chain, A op B first
                            pending_op <= key_op;
                            state      <= ST_WAIT_ALU;
                        end else begin
                            op_reg    <= key_op;      // latch or replace the operator
                            opd_b     <= '0;
                            digit_cnt <= '0;
                            neg       <= 1'b0;
                            state     <= ST_ENTRY_B;
                        end
                    end
                    KEY_EQUALS: begin
                        if (state == ST_ENTRY_B && digit_cnt != '0) begin
                            alu_start  <= 1'b1;
                            pending_op <= OP_NONE;    // land in result afterwards
                            state      <= ST_WAIT_ALU;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

/* verilog/calc_pkg.sv */
package calc_pkg;

    typedef logic [3:0] key_pos_t;  // row * 4 + col
    typedef logic [3:0] digit_t;    // decimal 0-9

    typedef enum logic [2:0] {
        KEY_DIGIT,
        KEY_OP,      // add, subtract, multiply
        KEY_MINUS,   // sign of the operand being entered
        KEY_EQUALS,
        KEY_CLEAR
    } key_class_t;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_ADD,
        OP_SUB,
        OP_MUL
    } op_t;

    localparam int OPERAND_W_DEFAULT = 16;
    localparam int MAX_DIGITS        = 4;

    // fixed keys of the matrix, digits 1-9 sit in columns 0-2 of rows 0-2
    localparam key_pos_t POS_ADD    = 4'd3;
    localparam key_pos_t POS_SUB    = 4'd7;
    localparam key_pos_t POS_MUL    = 4'd11;
    localparam key_pos_t POS_EQUALS = 4'd12;
    localparam key_pos_t POS_ZERO   = 4'd13;
    localparam key_pos_t POS_CLEAR  = 4'd14;
    localparam key_pos_t POS_MINUS  = 4'd15;

    // digit value back to its matrix position
    function automatic key_pos_t digit_pos(input digit_t d);
        int n;
        n = int'(d) - 1;
        if (d == 4'd0) begin
            return POS_ZERO;
        end
        return key_pos_t'((n / 3) * 4 + (n % 3));
    endfunction

    // matrix position to key meaning
    function automatic void decode_key(input key_pos_t pos, output key_class_t cls,
                                       output digit_t dig, output op_t op);
        cls = KEY_DIGIT;
        dig = 4'd0;
        op  = OP_NONE;
        case (pos)
            POS_ADD: begin
                cls = KEY_OP;
                op  = OP_ADD;
            end
            POS_SUB: begin
                cls = KEY_OP;
                op  = OP_SUB;
            end
            POS_MUL: begin
                cls = KEY_OP;
                op  = OP_MUL;
            end
            POS_EQUALS: cls = KEY_EQUALS;
            POS_CLEAR:  cls = KEY_CLEAR;
            POS_MINUS:  cls = KEY_MINUS;
            POS_ZERO:   dig = 4'd0;
            default:    dig = digit_t'(pos[3:2] * 3 + pos[1:0] + 1);  // 3x3 digit block
        endcase
    endfunction

endpackage

/* verilog/calc_top.sv */
module calc_top #(
    parameter int OPERAND_W       = calc_pkg::OPERAND_W_DEFAULT,
    parameter int SCAN_CYCLES     = 50000,    // 1 ms at 50 MHz
    parameter int DEBOUNCE_CYCLES = 500000    // 10 ms at 50 MHz
) (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic [3:0]                  row_in,
    output logic [3:0]                  col_out,
    output logic signed [OPERAND_W-1:0] display_value,
    output logic                        overflow,
    output logic                        key_click   // key_ack, drives a buzzer
);
    import calc_pkg::*;

    logic                        key_ready;
    key_class_t                  key_class;
    digit_t                      key_digit;
    op_t                         key_op;
    logic                        alu_start;
    op_t                         alu_op;
    logic signed [OPERAND_W-1:0] alu_a;
    logic signed [OPERAND_W-1:0] alu_b;
    logic                        alu_done;
    logic signed [OPERAND_W-1:0] alu_result;
    logic                        alu_overflow;

    keypad_scanner #(
        .SCAN_CYCLES     (SCAN_CYCLES),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) i_scanner (
        .clk       (clk),
        .nRST      (nRST),
        .row_in    (row_in),
        .col_out   (col_out),
        .key_ready (key_ready),
        .key_ack   (key_click),     // the ack pulse doubles as the click
        .key_class (key_class),
        .key_digit (key_digit),
        .key_op    (key_op)
    );

    calc_controller #(
        .OPERAND_W (OPERAND_W)
    ) i_controller (
        .clk           (clk),
        .nRST          (nRST),
        .key_ready     (key_ready),
        .key_class     (key_class),
        .key_digit     (key_digit),
        .key_op        (key_op),
        .key_ack       (key_click),
        .alu_start     (alu_start),
        .alu_op        (alu_op),
        .alu_a         (alu_a),
        .alu_b         (alu_b),
        .alu_done      (alu_done),
        .alu_result    (alu_result),
        .alu_overflow  (alu_overflow),
        .display_value (display_value),
        .overflow      (overflow)
    );

    calc_alu #(
        .OPERAND_W (OPERAND_W)
    ) i_alu (
        .clk          (clk),
        .nRST         (nRST),
        .alu_start    (alu_start),
        .alu_op       (alu_op),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_done     (alu_done),
        .alu_result   (alu_result),
        .alu_overflow (alu_overflow)
    );

endmodule

/* verilog/keypad_scanner.sv */
module keypad_scanner #(
    parameter int SCAN_CYCLES     = 50000,   // dwell per column, minus one
    parameter int DEBOUNCE_CYCLES = 500000   // cycles a row must stay low
) (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic [3:0]           row_in,     // active low, pulled up
    output logic [3:0]           col_out,    // one column low at a time
    output logic                 key_ready,  // level, held until key_ack
    input  logic                 key_ack,
    output calc_pkg::key_class_t key_class,
    output calc_pkg::digit_t     key_digit,
    output calc_pkg::op_t        key_op
);
    import calc_pkg::*;

    localparam int SCAN_W = $clog2(SCAN_CYCLES + 1);
    localparam int DB_W   = $clog2(DEBOUNCE_CYCLES + 1);

    typedef logic [SCAN_W-1:0] scan_cnt_t;
    typedef logic [DB_W-1:0]   db_cnt_t;

    typedef enum logic [1:0] {
        ST_SCAN,          // stepping the low column
        ST_WAIT_STABLE,   // debounce, column frozen
        ST_CONFIRM,       // key_ready high, waiting for ack
        ST_WAIT_RELEASE   // all rows must go high again
    } state_t;

    state_t     state;
    logic [1:0] col_idx;        // column currently driven low
    scan_cnt_t  scan_timer;
    db_cnt_t    debounce_cnt;
    logic [3:0] held_row;       // row pattern being debounced
    logic       any_low;
    logic [1:0] row_idx;
    key_pos_t   key_pos;
    key_class_t cls_dec;
    digit_t     dig_dec;
    op_t        op_dec;
    logic       load_key;       // debounce done this cycle

    assign any_low = (row_in != 4'b1111);

    always_comb begin
        col_out          = 4'b1111;
        col_out[col_idx] = 1'b0;
    end

    // lowest pressed row wins when several are low
    always_comb begin
        row_idx = 2'd0;
        for (int r = 3; r >= 0; r--) begin
            if (!held_row[r]) begin
                row_idx = 2'(r);
            end
        end
    end

    assign key_pos = {row_idx, col_idx};

    always_comb begin
        decode_key(key_pos, cls_dec, dig_dec, op_dec);
    end

    assign load_key = (state == ST_WAIT_STABLE) && (row_in == held_row) &&
                      (debounce_cnt == db_cnt_t'(DEBOUNCE_CYCLES));

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state        <= ST_SCAN;
            col_idx      <= 2'd0;
            scan_timer   <= '0;
            debounce_cnt <= '0;
            held_row     <= 4'b1111;
            key_ready    <= 1'b0;
        end else begin
            case (state)
                ST_SCAN: begin
                    if (any_low) begin
                        held_row     <= row_in;   // start debounce on this pattern
                        debounce_cnt <= '0;
                        state        <= ST_WAIT_STABLE;
                    end else if (scan_timer == scan_cnt_t'(SCAN_CYCLES)) begin
                        scan_timer <= '0;
                        col_idx    <= col_idx + 2'd1;  // wraps 3 -> 0
                    end else begin
                        scan_timer <= scan_timer + 1'b1;
                    end
                end
                ST_WAIT_STABLE: begin
                    if (!any_low) begin
                        // bounced open, rescan with a fresh dwell on the same column
                        scan_timer <= '0;
                        state      <= ST_SCAN;
                    end else if (row_in != held_row) begin
                        held_row     <= row_in;   // pattern changed, count again
                        debounce_cnt <= '0;
                    end else if (load_key) begin
                        key_ready <= 1'b1;        // meaning is loaded on this same edge
                        state     <= ST_CONFIRM;
                    end else begin
                        debounce_cnt <= debounce_cnt + 1'b1;
                    end
                end
                ST_CONFIRM: begin
                    if (key_ack) begin
                        key_ready <= 1'b0;
                        state     <= ST_WAIT_RELEASE;
                    end
                end
                ST_WAIT_RELEASE: begin
                    if (!any_low) begin
                        scan_timer <= '0;
                        state      <= ST_SCAN;
                    end
                end
                default: state <= ST_SCAN;
            endcase
        end
    end

    // key meaning, stable for as long as key_ready is high
    always_ff @(posedge clk) begin
        if (load_key) begin
            key_class <= cls_dec;
            key_digit <= dig_dec;
            key_op    <= op_dec;
        end
    end

endmodule
